//--- rtl/spi_pkg.sv
package spi_pkg;

   // frame width is fixed for the whole subsystem
   localparam int word_w = 8;

   // APB byte address width
   localparam int addr_w = 4;

   // one SPI data byte
   typedef logic [word_w-1:0] word_t;

   // APB byte address
   typedef logic [addr_w-1:0] apb_addr_t;

   // occupancy flags, one set per FIFO
   typedef struct packed {
      logic full;
      logic empty;
   } fifo_flags_t;

   // SPI engine phases
   typedef enum logic [2:0] {
      idle,
      lead,
      drive,
      sample,
      trail
   } spi_state_t;

   // register map
   localparam apb_addr_t status_addr = 4'h0;
   localparam apb_addr_t txdata_addr = 4'h4;
   localparam apb_addr_t rxdata_addr = 4'h8;

endpackage

//--- rtl/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo import spi_pkg::*; #(
   parameter int fifo_depth = 4
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        push,
   input  word_t       wdata,
   input  logic        pop,
   output word_t       rdata,
   output fifo_flags_t flags
);

   localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
   localparam int cnt_w = $clog2(fifo_depth + 1);

   typedef logic [ptr_w-1:0] ptr_t;
   typedef logic [cnt_w-1:0] cnt_t;

   word_t mem [fifo_depth];
   ptr_t  wr_ptr;
   ptr_t  rd_ptr;
   cnt_t  count;
   logic  do_push;
   logic  do_pop;

   // wrap at the last slot
   function automatic ptr_t next_ptr(input ptr_t ptr);
      if (ptr == ptr_t'(fifo_depth - 1)) begin
         return '0;
      end
      return ptr + ptr_t'(1);
   endfunction

   // requests against a full or empty buffer are dropped
   assign do_push = push && !flags.full;
   assign do_pop  = pop && !flags.empty;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + cnt_t'(1);
            2'b01:   count <= count - cnt_t'(1);
            default: count <= count;
         endcase
      end
   end

   // storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= wdata;
      end
   end

   // head of queue is visible without a pop
   assign rdata = mem[rd_ptr];

   assign flags.full  = (count == cnt_t'(fifo_depth));
   assign flags.empty = (count == '0);

endmodule

//--- rtl/apb_spi_regs.sv
`timescale 1ns/10ps

module apb_spi_regs import spi_pkg::*; (
   input  logic        clk,
   input  logic        rst,

   // APB slave
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  apb_addr_t   paddr,
   input  word_t       pwdata,
   output word_t       prdata,
   output logic        pready,
   output logic        pslverr,

   // transmit FIFO write side
   output logic        tx_push,
   output word_t       tx_wdata,
   input  fifo_flags_t tx_flags,

   // receive FIFO read side
   output logic        rx_pop,
   input  word_t       rx_rdata,
   input  fifo_flags_t rx_flags,

   // engine activity
   input  logic        busy
);

   logic  setup_q;
   logic  access;
   logic  wr_access;
   logic  rd_access;
   logic  sel_status;
   logic  sel_tx;
   logic  sel_rx;
   logic  tx_overflow;
   logic  rx_underflow;
   word_t status_word;

   // a setup cycle was seen just before this one
   always_ff @(posedge clk) begin
      if (rst) begin
         setup_q <= 1'b0;
      end else begin
         setup_q <= psel && !penable;
      end
   end

   // access phase lasts one cycle, no wait states
   assign access    = psel && penable && setup_q;
   assign wr_access = access && pwrite;
   assign rd_access = access && !pwrite;

   // address decode
   assign sel_status = (paddr == status_addr);
   assign sel_tx     = (paddr == txdata_addr);
   assign sel_rx     = (paddr == rxdata_addr);

   // error cases, only on the data registers
   assign tx_overflow  = wr_access && sel_tx && tx_flags.full;
   assign rx_underflow = rd_access && sel_rx && rx_flags.empty;

   // byte goes straight into the TX FIFO
   assign tx_push  = wr_access && sel_tx && !tx_flags.full;
   assign tx_wdata = pwdata;

   // reading RXDATA consumes the head entry
   assign rx_pop = rd_access && sel_rx && !rx_flags.empty;

   // status layout, upper bits stay zero
   always_comb begin
      status_word    = '0;
      status_word[0] = tx_flags.empty;
      status_word[1] = tx_flags.full;
      status_word[2] = rx_flags.empty;
      status_word[3] = rx_flags.full;
      status_word[4] = busy;
   end

   // read mux
   always_comb begin
      prdata = '0;
      if (rd_access) begin
         if (sel_status) begin
            prdata = status_word;
         end else if (sel_rx && !rx_flags.empty) begin
            prdata = rx_rdata;
         end
      end
   end

   assign pslverr = tx_overflow || rx_underflow;
   assign pready  = 1'b1;

endmodule

//--- rtl/spi_master.sv
`timescale 1ns/10ps

module spi_master import spi_pkg::*; #(
   parameter int spi_mode = 0,
   parameter int clk_div  = 3
) (
   input  logic        clk,
   input  logic        rst,

   // transmit FIFO read side
   input  word_t       tx_rdata,
   input  fifo_flags_t tx_flags,
   output logic        tx_pop,

   // receive FIFO write side
   output word_t       rx_wdata,
   input  fifo_flags_t rx_flags,
   output logic        rx_push,

   output logic        busy,

   // SPI bus
   output logic        sclk,
   output logic        cs,
   output logic        sdo,
   input  logic        sdi
);

   localparam int div_w   = (clk_div > 0) ? $clog2(clk_div + 1) : 1;
   localparam int bit_w   = $clog2(word_w);
   localparam int mid_cnt = clk_div / 2;

   typedef logic [div_w-1:0] div_t;
   typedef logic [bit_w-1:0] bit_t;

   spi_state_t state_reg;
   spi_state_t state_nxt;
   div_t       div_reg;
   div_t       div_nxt;
   bit_t       bit_reg;
   bit_t       bit_nxt;
   word_t      tx_sreg;
   word_t      tx_sreg_nxt;
   word_t      rx_sreg;
   word_t      rx_sreg_nxt;
   logic       cs_reg;
   logic       cs_nxt;
   logic       sclk_reg;
   logic       sclk_nxt;
   logic       cpol;
   logic       cpha;
   logic       phase_end;
   logic       mid_sample;
   logic       frame_ready;
   logic       start;
   logic       active_clk;

   // mode decoder
   always_comb begin
      case (spi_mode)
         1: begin
            cpol = 1'b0;
            cpha = 1'b1;
         end
         2: begin
            cpol = 1'b1;
            cpha = 1'b0;
         end
         3: begin
            cpol = 1'b1;
            cpha = 1'b1;
         end
         default: begin
            cpol = 1'b0;
            cpha = 1'b0;
         end
      endcase
   end

   // each phase is clk_div+1 cycles long
   assign phase_end  = (div_reg == div_t'(clk_div));
   assign mid_sample = (state_reg == sample) && (div_reg == div_t'(mid_cnt));

   // back-pressure: never start a byte that has nowhere to land
   assign frame_ready = !tx_flags.empty && !rx_flags.full;
   assign start       = frame_ready &&
                        ((state_reg == idle) || ((state_reg == trail) && phase_end));

   assign tx_pop  = start;
   assign rx_push = (state_reg == sample) && phase_end && (bit_reg == bit_t'(word_w - 1));

   // last bit may be captured on the push cycle itself when clk_div is 0
   assign rx_wdata = mid_sample ? {rx_sreg[word_w-2:0], sdi} : rx_sreg;

   always_comb begin
      state_nxt   = state_reg;
      div_nxt     = phase_end ? '0 : div_reg + div_t'(1);
      bit_nxt     = bit_reg;
      tx_sreg_nxt = tx_sreg;
      rx_sreg_nxt = rx_sreg;
      cs_nxt      = cs_reg;

      if (mid_sample) begin
         rx_sreg_nxt = {rx_sreg[word_w-2:0], sdi};
      end

      case (state_reg)
         idle: begin
            div_nxt = '0;
            if (start) begin
               state_nxt   = lead;
               bit_nxt     = '0;
               tx_sreg_nxt = tx_rdata;
               cs_nxt      = 1'b0;
            end
         end
         lead: begin
            if (phase_end) begin
               state_nxt = drive;
            end
         end
         drive: begin
            if (phase_end) begin
               state_nxt = sample;
            end
         end
         sample: begin
            if (phase_end) begin
               if (bit_reg == bit_t'(word_w - 1)) begin
                  state_nxt = trail;
                  bit_nxt   = '0;
               end else begin
                  // next bit onto sdo
                  state_nxt   = drive;
                  bit_nxt     = bit_reg + bit_t'(1);
                  tx_sreg_nxt = {tx_sreg[word_w-2:0], 1'b0};
               end
            end
         end
         trail: begin
            if (phase_end) begin
               if (start) begin
                  // back-to-back frame keeps cs low
                  state_nxt   = lead;
                  tx_sreg_nxt = tx_rdata;
               end else begin
                  state_nxt = idle;
                  cs_nxt    = 1'b1;
               end
            end
         end
         default: begin
            state_nxt = idle;
            cs_nxt    = 1'b1;
         end
      endcase
   end

   // look-ahead on the next phase keeps sclk registered
   assign active_clk = ((state_nxt == drive) && cpha) || ((state_nxt == sample) && !cpha);
   assign sclk_nxt   = cpol ^ active_clk;

   always_ff @(posedge clk) begin
      if (rst) begin
         state_reg <= idle;
         div_reg   <= '0;
         bit_reg   <= '0;
         cs_reg    <= 1'b1;
         sclk_reg  <= cpol;
      end else begin
         state_reg <= state_nxt;
         div_reg   <= div_nxt;
         bit_reg   <= bit_nxt;
         cs_reg    <= cs_nxt;
         sclk_reg  <= sclk_nxt;
      end
   end

   // shift registers
   always_ff @(posedge clk) begin
      tx_sreg <= tx_sreg_nxt;
      rx_sreg <= rx_sreg_nxt;
   end

   assign cs   = cs_reg;
   assign sclk = sclk_reg;
   assign sdo  = tx_sreg[word_w-1];
   assign busy = (state_reg != idle);

endmodule

//--- rtl/spi_subsys.sv
`timescale 1ns/10ps

module spi_subsys import spi_pkg::*; #(
   parameter int fifo_depth = 4,
   parameter int spi_mode   = 0,
   parameter int clk_div    = 3
) (
   input  logic      clk,
   input  logic      rst,

   // APB slave
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_addr_t paddr,
   input  word_t     pwdata,
   output word_t     prdata,
   output logic      pready,
   output logic      pslverr,

   // SPI bus
   output logic      sclk,
   output logic      cs,
   output logic      sdo,
   input  logic      sdi
);

   // transmit path
   logic        tx_push;
   word_t       tx_wdata;
   logic        tx_pop;
   word_t       tx_rdata;
   fifo_flags_t tx_flags;

   // receive path
   logic        rx_push;
   word_t       rx_wdata;
   logic        rx_pop;
   word_t       rx_rdata;
   fifo_flags_t rx_flags;

   logic        busy;

   apb_spi_regs u_regs (
      .clk      (clk),
      .rst      (rst),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .tx_push  (tx_push),
      .tx_wdata (tx_wdata),
      .tx_flags (tx_flags),
      .rx_pop   (rx_pop),
      .rx_rdata (rx_rdata),
      .rx_flags (rx_flags),
      .busy     (busy)
   );

   // CPU to engine
   sync_fifo #(
      .fifo_depth (fifo_depth)
   ) u_tx_fifo (
      .clk   (clk),
      .rst   (rst),
      .push  (tx_push),
      .wdata (tx_wdata),
      .pop   (tx_pop),
      .rdata (tx_rdata),
      .flags (tx_flags)
   );

   // engine to CPU
   sync_fifo #(
      .fifo_depth (fifo_depth)
   ) u_rx_fifo (
      .clk   (clk),
      .rst   (rst),
      .push  (rx_push),
      .wdata (rx_wdata),
      .pop   (rx_pop),
      .rdata (rx_rdata),
      .flags (rx_flags)
   );

   spi_master #(
      .spi_mode (spi_mode),
      .clk_div  (clk_div)
   ) u_master (
      .clk      (clk),
      .rst      (rst),
      .tx_rdata (tx_rdata),
      .tx_flags (tx_flags),
      .tx_pop   (tx_pop),
      .rx_wdata (rx_wdata),
      .rx_flags (rx_flags),
      .rx_push  (rx_push),
      .busy     (busy),
      .sclk     (sclk),
      .cs       (cs),
      .sdo      (sdo),
      .sdi      (sdi)
   );

endmodule

//--- verification/spi_subsys_assert.sv
`timescale 1ns/10ps

module spi_subsys_assert import spi_pkg::*; #(
   parameter int spi_mode = 0
) (
   input logic        clk,
   input logic        rst,
   input logic        cs,
   input logic        sclk,
   input logic        psel,
   input logic        penable,
   input logic        pslverr,
   input logic        rx_push,
   input fifo_flags_t rx_flags
);

   // modes 2 and 3 idle high
   localparam logic cpol = (spi_mode >= 2);

   sclk_idle: assert property (@(posedge clk) disable iff (rst) cs |-> (sclk == cpol))
      else $error("sclk away from its idle level while cs is high");

   // error response only in an access cycle
   slverr_access: assert property (@(posedge clk) disable iff (rst)
      pslverr |-> (psel && penable))
      else $error("pslverr outside an APB access cycle");

   rx_no_overrun: assert property (@(posedge clk) disable iff (rst)
      rx_push |-> !rx_flags.full)
      else $error("rx_push into a full RX FIFO");

endmodule

bind spi_subsys spi_subsys_assert #(
   .spi_mode (spi_mode)
) u_assert (
   .clk      (clk),
   .rst      (rst),
   .cs       (cs),
   .sclk     (sclk),
   .psel     (psel),
   .penable  (penable),
   .pslverr  (pslverr),
   .rx_push  (rx_push),
   .rx_flags (rx_flags)
);

//--- verification/tb_spi_subsys.sv
`timescale 1ns/10ps

module tb_spi_subsys import spi_pkg::*; ();

   logic      clk;
   logic      rst;
   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   word_t     pwdata;
   word_t     prdata;
   logic      pready;
   logic      pslverr;
   logic      sclk;
   logic      cs;
   logic      sdo;
   logic      sdi = 1'b0;

   int        errors = 0;
   int        checks = 0;
   int        cs_rises = 0;
   word_t     sent_q[$];
   word_t     slave_q[$];
   word_t     got_q[$];
   word_t     prev_sent = 8'h00;

   // SPI slave model state
   logic      cs_prev;
   logic      sclk_prev;
   int        slave_bits;
   word_t     slave_tx;
   word_t     slave_rx;
   word_t     slave_reply = 8'hA5;
   word_t     dropped_byte = 8'h00;
   logic      watch_drop = 1'b0;
   logic      dropped_seen = 1'b0;

   spi_subsys #(
      .fifo_depth (4),
      .spi_mode   (0),
      .clk_div    (3)
   ) u_dut (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .sclk    (sclk),
      .cs      (cs),
      .sdo     (sdo),
      .sdi     (sdi)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   // slave answers with the last byte it heard, xor A5
   function automatic word_t expected_reply(input word_t prev);
      return prev ^ 8'hA5;
   endfunction

   function automatic logic is_pending(input word_t b);
      foreach (sent_q[i]) begin
         if (sent_q[i] == b) begin
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   task automatic check_value(input string name, input word_t actual, input word_t expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAILED %s: got 0x%02h, expected 0x%02h", name, actual, expected);
      end
   endtask

   task automatic report_timeout(input string what);
      errors++;
      $display("timeout while waiting for %s", what);
   endtask

   task automatic apb_write(input apb_addr_t addr, input word_t data, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      #1;
      err = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_read(input apb_addr_t addr, output word_t data, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      #1;
      data = prdata;
      err  = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // accepted bytes feed the compare process
   task automatic write_byte(input word_t data);
      logic err;
      apb_write(txdata_addr, data, err);
      check_value("pslverr", word_t'(err), 8'h00);
      sent_q.push_back(data);
   endtask

   task automatic wait_status(input int bit_idx, input logic value, input string what);
      word_t st;
      logic  err;
      int    polls;
      polls = 0;
      apb_read(status_addr, st, err);
      while (st[bit_idx] !== value && polls < 500) begin
         apb_read(status_addr, st, err);
         polls++;
      end
      if (st[bit_idx] !== value) begin
         report_timeout(what);
      end
   endtask

   task automatic read_reply();
      word_t data;
      logic  err;
      wait_status(2, 1'b0, "a received byte");
      apb_read(rxdata_addr, data, err);
      check_value("pslverr", word_t'(err), 8'h00);
      got_q.push_back(data);
   endtask

   // mode 0 slave, tracks cs and sclk edges in one place
   always @(cs or sclk) begin
      if (cs_prev === 1'b1 && cs === 1'b0) begin
         slave_bits = 0;
         slave_tx   = slave_reply;
         sdi        = slave_tx[7];
      end else if (cs_prev === 1'b0 && cs === 1'b1) begin
         cs_rises++;
      end else if (cs === 1'b0 && sclk_prev === 1'b0 && sclk === 1'b1) begin
         slave_rx   = {slave_rx[6:0], sdo};
         slave_bits = slave_bits + 1;
         if (slave_bits == 8) begin
            slave_q.push_back(slave_rx);
            slave_reply = slave_rx ^ 8'hA5;
            if (watch_drop && slave_rx == dropped_byte) begin
               dropped_seen = 1'b1;
            end
         end
      end else if (cs === 1'b0 && sclk_prev === 1'b1 && sclk === 1'b0) begin
         // next reply is loaded between back-to-back frames
         if (slave_bits == 8) begin
            slave_bits = 0;
            slave_tx   = slave_reply;
         end else begin
            slave_tx = {slave_tx[6:0], 1'b0};
         end
         sdi = slave_tx[7];
      end
      cs_prev   = cs;
      sclk_prev = sclk;
   end

   // pair each byte read back with the byte that produced it
   always @(negedge clk) begin
      word_t sent;
      word_t heard;
      word_t got;
      if (got_q.size() > 0) begin
         got = got_q.pop_front();
         if (sent_q.size() == 0 || slave_q.size() == 0) begin
            errors++;
            $display("a byte was read back with no matching frame on the bus");
         end else begin
            sent  = sent_q.pop_front();
            heard = slave_q.pop_front();
            check_value("slave_rx", heard, sent);
            check_value("rxdata", got, expected_reply(prev_sent));
            prev_sent = sent;
         end
      end
   end

   initial begin
      word_t st;
      word_t data;
      logic  err;
      int    rises;
      int    low;
      void'($urandom(69));
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // reset state
      apb_read(status_addr, st, err);
      check_value("status", st, 8'h05);
      check_value("cs", word_t'(cs), 8'h01);
      check_value("pready", word_t'(pready), 8'h01);

      // single round trip
      write_byte(word_t'($urandom()));
      read_reply();
      wait_status(4, 1'b0, "the engine to go idle");

      // burst, cs held low across frames
      rises = cs_rises;
      repeat (4) write_byte(word_t'($urandom()));
      wait_status(3, 1'b1, "a full RX FIFO after the burst");
      wait_status(4, 1'b0, "the engine to go idle after the burst");
      check_value("cs rises", word_t'(cs_rises - rises), 8'h01);
      repeat (4) read_reply();

      // stall the engine, then overfill TX
      repeat (4) write_byte(word_t'($urandom()));
      wait_status(3, 1'b1, "a full RX FIFO");
      wait_status(4, 1'b0, "the engine to stall");
      repeat (4) write_byte(word_t'($urandom()));
      apb_read(status_addr, st, err);
      check_value("status", st, 8'h0A);
      dropped_byte = word_t'($urandom());
      while (is_pending(dropped_byte)) begin
         dropped_byte = dropped_byte + 8'd1;
      end
      watch_drop = 1'b1;
      apb_write(txdata_addr, dropped_byte, err);
      check_value("pslverr", word_t'(err), 8'h01);

      // back-pressure keeps cs high
      low = 0;
      repeat (200) begin
         @(negedge clk);
         if (cs !== 1'b1) begin
            low++;
         end
      end
      check_value("cs low cycles", word_t'(low), 8'h00);
      apb_read(status_addr, st, err);
      check_value("status", st, 8'h0A);

      // drain, transmission resumes
      repeat (8) read_reply();
      wait_status(4, 1'b0, "the engine to finish");
      check_value("dropped byte sent", word_t'(dropped_seen), 8'h00);
      apb_read(rxdata_addr, data, err);
      check_value("prdata", data, 8'h00);
      check_value("pslverr", word_t'(err), 8'h01);

      repeat (2) @(negedge clk);
      check_value("unmatched sent bytes", word_t'(sent_q.size()), 8'h00);
      check_value("unmatched slave bytes", word_t'(slave_q.size()), 8'h00);

      $display("run complete: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- sim.f
rtl/spi_pkg.sv
rtl/sync_fifo.sv
rtl/apb_spi_regs.sv
rtl/spi_master.sv
rtl/spi_subsys.sv
verification/spi_subsys_assert.sv
verification/tb_spi_subsys.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_spi_subsys
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := SIMULATION PASSED
SIM_FLAGS  := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
